// ==== verilog.f ====
rtl/ppu_pkg.sv
rtl/n64_vinfo.sv
rtl/n64_vdemux.sv
rtl/video_window.sv
rtl/vmode_select.sv
rtl/n64_ppu_top.sv
testbench/tb_n64_ppu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the N64 video front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_n64_ppu_top \
  && ./obj_dir/Vtb_n64_ppu_top \
  || { echo "Simulation failed"; exit 1; }

echo "Simulation finished"

// ==== testbench/tb_n64_ppu_top.sv ====
// =========================================================
// N64 video front end testbench
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module tb_n64_ppu_top;

  import ppu_pkg::*;

  // Short lines for the detection fields, long lines for the window frames
  localparam int SHORT_PPL = 8;
  localparam int WIN_PPL   = 672;
  localparam int WIN_LINES = 256;
  localparam int HS_PIX    = 2;
  localparam int VS_LINES  = 3;
  localparam int WATCHDOG_CYCLES =
    2 * WIN_LINES * WIN_PPL * 4 + 16 * 320 * SHORT_PPL * 4 + 20000;

  logic                   clk;
  logic                   rst;
  logic                   nvdsync;
  color_i_t               vd_in;
  ppu_cfg_t               cfg;
  logic                   vsync;
  logic                   hsync;
  logic                   de;
  logic [3*COLOR_W_O-1:0] vd_out;
  ppu_state_t             ppu_state;

  // Expected outputs of the pixel now in flight
  logic                   exp_valid;
  logic                   exp_de;
  logic                   exp_hs;
  logic                   exp_vs;
  logic [3*COLOR_W_O-1:0] exp_vd;
  int                     de_count;
  logic [31:0]            lfsr_q;

  n64_ppu_top n64_ppu_top_inst (
    .N64_CLK_i   (clk),
    .rst_i       (rst),
    .nVDSYNC_i   (nvdsync),
    .VD_i        (vd_in),
    .cfg_i       (cfg),
    .VSYNC_o     (vsync),
    .HSYNC_o     (hsync),
    .DE_o        (de),
    .VD_o        (vd_out),
    .ppu_state_o (ppu_state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
  end

  // =========================================================
  // Helpers
  // =========================================================
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  function automatic color_i_t rand_color();
    color_i_t c;
    c = '0;
    for (int i = 0; i < COLOR_W_I; i++) begin
      c = {c[COLOR_W_I-2:0], lfsr_bit()};
    end
    return c;
  endfunction

  // Optional 16-bit cut, then MSB replicated into the new LSB
  function automatic color_o_t expected_color(input color_i_t c, input logic n16);
    color_i_t m;
    m = n16 ? (c & 7'h7C) : c;
    return {m, m[COLOR_W_I-1]};
  endfunction

  function automatic vmode_t expected_vmode(input ppu_cfg_t c, input logic pal);
    logic pick_pal;
    pick_pal = pal;
    if (!c.llm && c.target_res != TGT_LOWRES) begin
      if (c.force60) begin
        pick_pal = 1'b0;
      end else if (c.force50) begin
        pick_pal = 1'b1;
      end
    end
    case (c.target_res)
      TGT_LOWRES:   return pick_pal ? VM_288P50 : VM_240P60;
      TGT_480P576P: return pick_pal ? VM_576P50 : (c.use_vga_480p ? VM_VGAP60 : VM_480P60);
      TGT_720P:     return pick_pal ? VM_720P50 : VM_720P60;
      TGT_960P:     return pick_pal ? VM_960P50 : VM_960P60;
      TGT_1080P:    return pick_pal ? VM_1080P50 : VM_1080P60;
      TGT_1200P:    return pick_pal ? VM_1200P50 : VM_1200P60;
      TGT_1440P:    return pick_pal ? VM_1440P50 : VM_1440P60;
      default:      return pick_pal ? VM_1440WP50 : VM_1440WP60;
    endcase
  endfunction

  function automatic ppu_cfg_t default_cfg();
    ppu_cfg_t c;
    c = '0;
    c.target_res = TGT_480P576P;
    c.vsl_en     = 1'b1;
    return c;
  endfunction

  // =========================================================
  // Bus driver
  // =========================================================

  // Previous pixel reaches the outputs while this one is on the bus
  task automatic check_prev(input bit count_de);
    if (exp_valid) begin
      check_value("DE_o", de, exp_de);
      check_value("HSYNC_o", hsync, exp_hs);
      check_value("VSYNC_o", vsync, exp_vs);
      check_value("VD_o", vd_out, exp_vd);
      if (count_de && de) begin
        de_count++;
      end
    end
  endtask

  task automatic send_pixel(input int p, input int l);
    sync_t    sy;
    color_i_t r;
    color_i_t g;
    color_i_t b;
    int       h0;
    int       v0;
    r = rand_color();
    g = rand_color();
    b = rand_color();
    sy.nvsync = !(l < VS_LINES);
    sy.nclamp = 1'b1;
    sy.nhsync = !(p < HS_PIX);
    sy.ncsync = sy.nvsync & sy.nhsync;
    nvdsync = 1'b0;
    vd_in   = {3'b000, sy};
    step();
    check_prev(1'b1);
    nvdsync = 1'b1;
    vd_in   = r;
    step();
    vd_in = g;
    step();
    vd_in = b;
    step();
    // This pixel is not on the outputs yet, the previous one still holds
    check_prev(1'b0);
    h0 = H_START_BASE + int'(cfg.hshift);
    v0 = V_START_BASE + int'(cfg.vshift);
    exp_valid = 1'b1;
    exp_de = (p >= h0) && (p < h0 + H_ACTIVE) && (l >= v0) && (l < v0 + V_ACTIVE);
    exp_hs = sy.nhsync;
    exp_vs = sy.nvsync;
    exp_vd = {expected_color(r, cfg.n16bit_mode), expected_color(g, cfg.n16bit_mode),
              expected_color(b, cfg.n16bit_mode)};
  endtask

  // Field starts with VSYNC and HSYNC falling on its first pixel
  task automatic send_field(input int lines, input int ppl);
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < ppl; p++) begin
        send_pixel(p, l);
      end
    end
  endtask

  task automatic flush();
    vd_in = '0;
    step();
    check_prev(1'b1);
    exp_valid = 1'b0;
  endtask

  task automatic check_vinfo(input logic pal, input logic i480);
    check_value("ppu_state_o.input_pal", ppu_state.input_pal, pal);
    check_value("ppu_state_o.input_480i", ppu_state.input_480i, i480);
    check_value("ppu_state_o.vmode", ppu_state.vmode, expected_vmode(cfg, pal));
  endtask

  // =========================================================
  // Directed tests
  // =========================================================
  task automatic test_reset_state();
    check_value("DE_o", de, 1'b0);
    check_value("HSYNC_o", hsync, 1'b1);
    check_value("VSYNC_o", vsync, 1'b1);
    check_value("ppu_state_o.vmode", ppu_state.vmode, VM_480P60);
    check_value("ppu_state_o.input_pal", ppu_state.input_pal, 1'b0);
    check_value("ppu_state_o.input_480i", ppu_state.input_480i, 1'b0);
  endtask

  // Flags judge the field that ended, so one extra field is sent
  task automatic test_vinfo(input int len_a, input int len_b, input int fields,
                            input logic pal, input logic i480);
    for (int f = 0; f < fields; f++) begin
      send_field((f % 2 == 0) ? len_a : len_b, SHORT_PPL);
    end
    flush();
    check_vinfo(pal, i480);
  endtask

  task automatic test_mode_select(input logic pal);
    ppu_cfg_t c;
    for (int t = 0; t < 8; t++) begin
      for (int k = 0; k < 16; k++) begin
        c = default_cfg();
        c.target_res   = res_target_t'(t[2:0]);
        c.use_vga_480p = k[0];
        c.force60      = k[1];
        c.force50      = k[2];
        c.llm          = k[3];
        c.vsl_en       = k[0];
        c.hsl_en       = !k[0];
        cfg = c;
        step();
        check_value("ppu_state_o.vmode", ppu_state.vmode, expected_vmode(c, pal));
        check_value("ppu_state_o.vsl_en", ppu_state.vsl_en, (t != 0) && k[0]);
        check_value("ppu_state_o.hsl_en", ppu_state.hsl_en, (t != 0) && !k[0]);
        check_value("ppu_state_o.llm", ppu_state.llm, k[3]);
        check_value("ppu_state_o.input_pal", ppu_state.input_pal, pal);
      end
    end
    cfg = default_cfg();
    step();
  endtask

  task automatic test_pixel_path(input logic n16);
    cfg.n16bit_mode = n16;
    step();
    step();
    check_value("ppu_state_o.color_16bit", ppu_state.color_16bit, n16);
    send_field(20, SHORT_PPL);
    flush();
  endtask

  task automatic test_window(input int hs, input int vs);
    cfg.hshift = shift_t'(hs);
    cfg.vshift = shift_t'(vs);
    step();
    step();
    de_count = 0;
    send_field(WIN_LINES, WIN_PPL);
    flush();
    check_value("DE_o high count", de_count, H_ACTIVE * V_ACTIVE);
  endtask

  initial begin
    rst       = 1'b1;
    nvdsync   = 1'b1;
    vd_in     = '0;
    cfg       = default_cfg();
    exp_valid = 1'b0;
    exp_de    = 1'b0;
    exp_hs    = 1'b1;
    exp_vs    = 1'b1;
    exp_vd    = '0;
    de_count  = 0;
    lfsr_q    = 32'd73745;
    repeat (10) @(posedge clk);
    #2;
    test_reset_state();
    rst = 1'b0;
    step();
    step();
    test_reset_state();

    test_vinfo(262, 262, 4, 1'b0, 1'b0);
    test_mode_select(1'b0);
    test_vinfo(312, 312, 3, 1'b1, 1'b0);
    test_mode_select(1'b1);
    test_vinfo(263, 262, 4, 1'b0, 1'b1);

    test_pixel_path(1'b0);
    test_pixel_path(1'b1);
    test_pixel_path(1'b0);

    test_window(0, 0);
    test_window(5, 3);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/n64_ppu_top.sv ====
// =========================================================
// N64 video front end top
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module n64_ppu_top (
  input  logic                            N64_CLK_i,
  input  logic                            rst_i,
  input  logic                            nVDSYNC_i,
  input  ppu_pkg::color_i_t               VD_i,
  input  ppu_pkg::ppu_cfg_t               cfg_i,
  output logic                            VSYNC_o,
  output logic                            HSYNC_o,
  output logic                            DE_o,
  output logic [3*ppu_pkg::COLOR_W_O-1:0] VD_o,
  output ppu_pkg::ppu_state_t             ppu_state_o
);

  import ppu_pkg::*;

  sync_t  sync_w;
  vinfo_t vinfo_w;
  pixel_t pixel_w;
  logic   pix_valid_w;
  logic   n16bit_mode_w;
  shift_t hshift_w;
  shift_t vshift_w;

  // Low nibble of the bus is the sync byte on nVDSYNC clocks
  assign sync_w = VD_i[3:0];

  n64_vinfo n64_vinfo_inst (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .nVDSYNC_i (nVDSYNC_i),
    .sync_i    (sync_w),
    .vinfo_o   (vinfo_w)
  );

  n64_vdemux n64_vdemux_inst (
    .N64_CLK_i     (N64_CLK_i),
    .rst_i         (rst_i),
    .nVDSYNC_i     (nVDSYNC_i),
    .VD_i          (VD_i),
    .n16bit_mode_i (n16bit_mode_w),
    .pixel_o       (pixel_w),
    .pix_valid_o   (pix_valid_w)
  );

  video_window video_window_inst (
    .N64_CLK_i   (N64_CLK_i),
    .rst_i       (rst_i),
    .pixel_i     (pixel_w),
    .pix_valid_i (pix_valid_w),
    .hshift_i    (hshift_w),
    .vshift_i    (vshift_w),
    .VSYNC_o     (VSYNC_o),
    .HSYNC_o     (HSYNC_o),
    .DE_o        (DE_o),
    .VD_o        (VD_o)
  );

  vmode_select vmode_select_inst (
    .N64_CLK_i     (N64_CLK_i),
    .rst_i         (rst_i),
    .cfg_i         (cfg_i),
    .vinfo_i       (vinfo_w),
    .n16bit_mode_o (n16bit_mode_w),
    .hshift_o      (hshift_w),
    .vshift_o      (vshift_w),
    .ppu_state_o   (ppu_state_o)
  );

endmodule

`default_nettype wire

// ==== rtl/vmode_select.sv ====
// =========================================================
// Output video mode decode
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module vmode_select (
  input  logic                N64_CLK_i,
  input  logic                rst_i,
  input  ppu_pkg::ppu_cfg_t   cfg_i,
  input  ppu_pkg::vinfo_t     vinfo_i,
  output logic                n16bit_mode_o,
  output ppu_pkg::shift_t     hshift_o,
  output ppu_pkg::shift_t     vshift_o,
  output ppu_pkg::ppu_state_t ppu_state_o
);

  import ppu_pkg::*;

  vmode_t ntsc_mode;
  vmode_t pal_mode;
  vmode_t vmode_next;
  logic   lowres;
  logic   force_ok;
  logic   use_pal;

  // =========================================================
  // Mode tables
  // =========================================================
  always_comb begin
    case (cfg_i.target_res)
      TGT_LOWRES:   ntsc_mode = VM_240P60;
      TGT_480P576P: ntsc_mode = cfg_i.use_vga_480p ? VM_VGAP60 : VM_480P60;
      TGT_720P:     ntsc_mode = VM_720P60;
      TGT_960P:     ntsc_mode = VM_960P60;
      TGT_1080P:    ntsc_mode = VM_1080P60;
      TGT_1200P:    ntsc_mode = VM_1200P60;
      TGT_1440P:    ntsc_mode = VM_1440P60;
      default:      ntsc_mode = VM_1440WP60;
    endcase
  end

  always_comb begin
    case (cfg_i.target_res)
      TGT_LOWRES:   pal_mode = VM_288P50;
      TGT_480P576P: pal_mode = VM_576P50;
      TGT_720P:     pal_mode = VM_720P50;
      TGT_960P:     pal_mode = VM_960P50;
      TGT_1080P:    pal_mode = VM_1080P50;
      TGT_1200P:    pal_mode = VM_1200P50;
      TGT_1440P:    pal_mode = VM_1440P50;
      default:      pal_mode = VM_1440WP50;
    endcase
  end

  assign lowres = cfg_i.target_res == TGT_LOWRES;

  // No frame rate forcing in low latency mode or at native resolution
  assign force_ok = !cfg_i.llm && !lowres;

  always_comb begin
    if (force_ok && cfg_i.force60) begin
      use_pal = 1'b0;
    end else if (force_ok && cfg_i.force50) begin
      use_pal = 1'b1;
    end else begin
      use_pal = vinfo_i.palmode;
    end
  end

  assign vmode_next = use_pal ? pal_mode : ntsc_mode;

  // =========================================================
  // State register
  // =========================================================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      n16bit_mode_o <= 1'b0;
      hshift_o      <= '0;
      vshift_o      <= '0;
      ppu_state_o   <= '0;
      ppu_state_o.vmode <= VM_480P60;
    end else begin
      n16bit_mode_o <= cfg_i.n16bit_mode;
      hshift_o      <= cfg_i.hshift;
      vshift_o      <= cfg_i.vshift;

      ppu_state_o.rsvd        <= 1'b0;
      ppu_state_o.input_pal   <= vinfo_i.palmode;
      ppu_state_o.input_480i  <= vinfo_i.n64_480i;
      ppu_state_o.vmode       <= vmode_next;
      // Scanlines are meaningless at 240p/288p
      ppu_state_o.vsl_en      <= cfg_i.vsl_en && !lowres;
      ppu_state_o.hsl_en      <= cfg_i.hsl_en && !lowres;
      ppu_state_o.color_16bit <= cfg_i.n16bit_mode;
      ppu_state_o.llm         <= cfg_i.llm;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/video_window.sv ====
// =========================================================
// Output window and colour expansion
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module video_window (
  input  logic                            N64_CLK_i,
  input  logic                            rst_i,
  input  ppu_pkg::pixel_t                 pixel_i,
  input  logic                            pix_valid_i,
  input  ppu_pkg::shift_t                 hshift_i,
  input  ppu_pkg::shift_t                 vshift_i,
  output logic                            VSYNC_o,
  output logic                            HSYNC_o,
  output logic                            DE_o,
  output logic [3*ppu_pkg::COLOR_W_O-1:0] VD_o
);

  import ppu_pkg::*;

  logic      nhsync_q;
  logic      nvsync_q;
  logic      hsync_fall;
  logic      vsync_fall;
  pix_cnt_t  h_cnt_q;
  pix_cnt_t  h_idx;
  pix_cnt_t  h_start;
  pix_cnt_t  h_end;
  line_cnt_t v_cnt_q;
  line_cnt_t v_idx;
  line_cnt_t v_start;
  line_cnt_t v_end;
  logic      de_next;

  // 7 to 8 bits by repeating the MSB
  function automatic color_o_t expand(input color_i_t c);
    return {c, c[COLOR_W_I-1]};
  endfunction

  assign hsync_fall = nhsync_q && !pixel_i.sync.nhsync;
  assign vsync_fall = nvsync_q && !pixel_i.sync.nvsync;

  // Index of the pixel now on the input, counters saturate
  always_comb begin
    if (hsync_fall) begin
      h_idx = '0;
    end else if (h_cnt_q == '1) begin
      h_idx = h_cnt_q;
    end else begin
      h_idx = h_cnt_q + 1'b1;
    end

    if (vsync_fall) begin
      v_idx = '0;
    end else if (hsync_fall && v_cnt_q != '1) begin
      v_idx = v_cnt_q + 1'b1;
    end else begin
      v_idx = v_cnt_q;
    end
  end

  assign h_start = pix_cnt_t'(H_START_BASE) + pix_cnt_t'(hshift_i);
  assign h_end   = h_start + pix_cnt_t'(H_ACTIVE);
  assign v_start = line_cnt_t'(V_START_BASE) + line_cnt_t'(vshift_i);
  assign v_end   = v_start + line_cnt_t'(V_ACTIVE);

  assign de_next = (h_idx >= h_start) && (h_idx < h_end) &&
                   (v_idx >= v_start) && (v_idx < v_end);

  // Counters and sync levels move only on pixel strobes
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      nhsync_q <= 1'b1;
      nvsync_q <= 1'b1;
      h_cnt_q  <= '0;
      v_cnt_q  <= '0;
      DE_o     <= 1'b0;
      HSYNC_o  <= 1'b1;
      VSYNC_o  <= 1'b1;
    end else if (pix_valid_i) begin
      nhsync_q <= pixel_i.sync.nhsync;
      nvsync_q <= pixel_i.sync.nvsync;
      h_cnt_q  <= h_idx;
      v_cnt_q  <= v_idx;
      DE_o     <= de_next;
      HSYNC_o  <= pixel_i.sync.nhsync;
      VSYNC_o  <= pixel_i.sync.nvsync;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      VD_o <= {expand(pixel_i.red), expand(pixel_i.green), expand(pixel_i.blue)};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/n64_vdemux.sv ====
// =========================================================
// N64 video bus demultiplexer
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module n64_vdemux (
  input  logic              N64_CLK_i,
  input  logic              rst_i,
  input  logic              nVDSYNC_i,
  input  ppu_pkg::color_i_t VD_i,
  input  logic              n16bit_mode_i,
  output ppu_pkg::pixel_t   pixel_o,
  output logic              pix_valid_o
);

  import ppu_pkg::*;

  // Phase names the byte expected on the current clock
  demux_phase_t phase_q;
  sync_t        sync_q;
  color_i_t     red_q;
  color_i_t     green_q;
  color_i_t     vd_masked;

  // 16-bit colour keeps only the five upper bits
  assign vd_masked = n16bit_mode_i ? {VD_i[COLOR_W_I-1:2], 2'b00} : VD_i;

  // =========================================================
  // Phase FSM
  // =========================================================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      phase_q     <= PH_SYNC;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (!nVDSYNC_i) begin
        // Sync byte, realign whatever the phase was
        phase_q <= PH_RED;
      end else begin
        case (phase_q)
          PH_RED:   phase_q <= PH_GREEN;
          PH_GREEN: phase_q <= PH_BLUE;
          PH_BLUE: begin
            phase_q     <= PH_SYNC;
            pix_valid_o <= 1'b1;
          end
          default:  phase_q <= PH_SYNC;
        endcase
      end
    end
  end

  // =========================================================
  // Byte capture
  // =========================================================
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_q.nvsync <= VD_i[SY_VSYNC_BIT];
      sync_q.nclamp <= VD_i[SY_CLAMP_BIT];
      sync_q.nhsync <= VD_i[SY_HSYNC_BIT];
      sync_q.ncsync <= VD_i[SY_CSYNC_BIT];
    end else if (phase_q == PH_RED) begin
      red_q <= vd_masked;
    end else if (phase_q == PH_GREEN) begin
      green_q <= vd_masked;
    end else if (phase_q == PH_BLUE) begin
      // Blue goes straight into the output pixel
      pixel_o.sync  <= sync_q;
      pixel_o.red   <= red_q;
      pixel_o.green <= green_q;
      pixel_o.blue  <= vd_masked;
    end
  end

  // =========================================================
  // Checks
  // =========================================================

  // One strobe per four-clock pixel
  a_valid_single: assert property (
    @(posedge N64_CLK_i) disable iff (rst_i)
    pix_valid_o |=> !pix_valid_o
  );

  // A sync byte always starts a new pixel
  a_sync_restart: assert property (
    @(posedge N64_CLK_i) disable iff (rst_i)
    !nVDSYNC_i |=> (phase_q != PH_SYNC)
  );

endmodule

`default_nettype wire

// ==== rtl/n64_vinfo.sv ====
// =========================================================
// N64 PAL and 480i detection
// =========================================================

`timescale 1ns/1ns
`default_nettype none

module n64_vinfo (
  input  logic            N64_CLK_i,
  input  logic            rst_i,
  input  logic            nVDSYNC_i,
  input  ppu_pkg::sync_t  sync_i,
  output ppu_pkg::vinfo_t vinfo_o
);

  import ppu_pkg::*;

  // Sync levels of the previous sync byte
  logic      nvsync_q;
  logic      nhsync_q;
  logic      vsync_fall;
  logic      hsync_fall;
  line_cnt_t line_cnt_q;
  line_cnt_t prev_cnt_q;

  // Edges are only seen on sync byte clocks
  assign vsync_fall = !nVDSYNC_i && nvsync_q && !sync_i.nvsync;
  assign hsync_fall = !nVDSYNC_i && nhsync_q && !sync_i.nhsync;

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      nvsync_q   <= 1'b1;
      nhsync_q   <= 1'b1;
      line_cnt_q <= '0;
      prev_cnt_q <= '0;
      vinfo_o    <= '0;
    end else begin
      if (!nVDSYNC_i) begin
        nvsync_q <= sync_i.nvsync;
        nhsync_q <= sync_i.nhsync;
      end

      if (vsync_fall) begin
        // Field finished, judge its length
        vinfo_o.palmode  <= line_cnt_q > line_cnt_t'(PAL_LINE_THRESH);
        // Odd and even fields differ by one line in 480i
        vinfo_o.n64_480i <= line_cnt_q != prev_cnt_q;
        prev_cnt_q       <= line_cnt_q;
        // An HSYNC fall on the VSYNC byte opens line 1 of the new field
        line_cnt_q       <= hsync_fall ? line_cnt_t'(1) : '0;
      end else if (hsync_fall && line_cnt_q != '1) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

  // =========================================================
  // Checks
  // =========================================================

  // Interlace flag only moves right after a field boundary
  a_480i_on_vsync: assert property (
    @(posedge N64_CLK_i) disable iff (rst_i)
    (vinfo_o.n64_480i != $past(vinfo_o.n64_480i)) |-> $past(vsync_fall)
  );

endmodule

`default_nettype wire

// ==== rtl/ppu_pkg.sv ====
// =========================================================
// N64 video front end definitions
// =========================================================

`default_nettype none

package ppu_pkg;

  // =========================================================
  // Widths and plain types
  // =========================================================
  localparam int COLOR_W_I = 7;
  localparam int COLOR_W_O = 8;

  typedef logic [COLOR_W_I-1:0] color_i_t;
  typedef logic [COLOR_W_O-1:0] color_o_t;
  typedef logic [9:0]           line_cnt_t;
  typedef logic [9:0]           pix_cnt_t;
  typedef logic [4:0]           shift_t;

  // Field length above this is a 50 Hz source
  localparam int PAL_LINE_THRESH = 290;

  // Data-enable window, origin before shift
  localparam int H_START_BASE = 16;
  localparam int V_START_BASE = 8;
  localparam int H_ACTIVE     = 640;
  localparam int V_ACTIVE     = 240;

  // Sync byte layout on VD[3:0], all active low
  localparam int SY_VSYNC_BIT = 3;
  localparam int SY_CLAMP_BIT = 2;
  localparam int SY_HSYNC_BIT = 1;
  localparam int SY_CSYNC_BIT = 0;

  // =========================================================
  // Enums
  // =========================================================
  typedef enum logic [1:0] {
    PH_SYNC, PH_RED, PH_GREEN, PH_BLUE
  } demux_phase_t;

  // TGT_LOWRES covers 240p and 288p
  typedef enum logic [2:0] {
    TGT_LOWRES, TGT_480P576P, TGT_720P, TGT_960P,
    TGT_1080P, TGT_1200P, TGT_1440P, TGT_1440WP
  } res_target_t;

  typedef enum logic [4:0] {
    VM_240P60, VM_480P60, VM_VGAP60, VM_720P60, VM_960P60,
    VM_1080P60, VM_1200P60, VM_1440P60, VM_1440WP60,
    VM_288P50, VM_576P50, VM_720P50, VM_960P50,
    VM_1080P50, VM_1200P50, VM_1440P50, VM_1440WP50
  } vmode_t;

  // =========================================================
  // Bundles
  // =========================================================
  typedef struct packed {
    logic palmode;
    logic n64_480i;
  } vinfo_t;

  // Same order as the bus bits
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  typedef struct packed {
    sync_t    sync;
    color_i_t red;
    color_i_t green;
    color_i_t blue;
  } pixel_t;

  typedef struct packed {
    res_target_t target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        llm;
    logic        n16bit_mode;
    shift_t      hshift;
    shift_t      vshift;
    logic        vsl_en;
    logic        hsl_en;
  } ppu_cfg_t;

  // Top bit is spare and reads 0
  typedef struct packed {
    logic   rsvd;
    logic   input_pal;
    logic   input_480i;
    vmode_t vmode;
    logic   vsl_en;
    logic   hsl_en;
    logic   color_16bit;
    logic   llm;
  } ppu_state_t;

endpackage

`default_nettype wire
